// File: source/lsuMacros.svh
`ifndef LSU_MACROS_SVH
`define LSU_MACROS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// data-memory path sizes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// byte address, covers the whole RAM.
`define LSU_ADDR_W 17

// widest load or store is one word.
`define LSU_DATA_W 32

// one tag per load/store buffer entry.
`define LSU_TAG_W 4

// memory is byte wide, one byte per address.
`define LSU_RAM_DEPTH (1 << `LSU_ADDR_W)

`endif

// File: source/lsuPkg.sv
`default_nettype none

`include "lsuMacros.svh"

package lsuPkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // vector types
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef logic [`LSU_ADDR_W-1:0] addrT;
    typedef logic [`LSU_DATA_W-1:0] dataT;
    typedef logic [`LSU_TAG_W-1:0]  tagT;
    typedef logic [1:0]             sizeT;  // 0 byte, 1 halfword, 2 word.
    typedef logic [7:0]             byteT;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // controller states
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [1:0] {
        ctrlIdle,
        ctrlAccess,
        ctrlFinish
    } ctrlStateT;

endpackage

`default_nettype wire

// File: source/byteCounter.sv
`timescale 1ns/1ps
`default_nettype none

module byteCounter (
    input  wire                clk,
    input  wire                arstN,
    input  wire                cntClear,
    input  wire                cntStep,
    input  wire  lsuPkg::sizeT cntSize,
    output logic [1:0]         byteIdx,
    output logic               lastByte
);

    logic [1:0] lastIdx;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            byteIdx <= 2'd0;
        end else if (cntClear) begin
            byteIdx <= 2'd0;
        end else if (cntStep) begin
            byteIdx <= byteIdx + 2'd1;
        end
    end

    always_comb begin
        case (cntSize)
            2'd0:    lastIdx = 2'd0;
            2'd1:    lastIdx = 2'd1;
            default: lastIdx = 2'd3;  // code 3 is never issued.
        endcase
    end

    assign lastByte = (byteIdx == lastIdx);

endmodule

`default_nettype wire

// File: source/byteRam.sv
`timescale 1ns/1ps
`include "lsuMacros.svh"
`default_nettype none

module byteRam (
    input  wire                clk,
    input  wire                ramEn,
    input  wire                ramWe,
    input  wire  lsuPkg::addrT ramAddr,
    input  wire  lsuPkg::byteT ramWdata,
    output lsuPkg::byteT       ramRdata
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // storage
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    lsuPkg::byteT mem [`LSU_RAM_DEPTH];

    // one port, so an edge either writes or reads.
    always_ff @(posedge clk) begin
        if (ramEn) begin
            if (ramWe) begin
                mem[ramAddr] <= ramWdata;
            end else begin
                ramRdata <= mem[ramAddr];  // valid in the following cycle.
            end
        end
    end

endmodule

`default_nettype wire

// File: source/memCtrlFsm.sv
`timescale 1ns/1ps
`default_nettype none

module memCtrlFsm (
    input  wire                clk,
    input  wire                arstN,
    input  wire                flush,
    // held request
    input  wire                memReq,
    input  wire                memStore,
    input  wire  lsuPkg::addrT memAddr,
    input  wire  lsuPkg::dataT memData,
    input  wire  lsuPkg::sizeT memSize,
    output logic               memDone,
    output lsuPkg::dataT       memRdata,
    // byte counter
    input  wire  [1:0]         byteIdx,
    input  wire                lastByte,
    output logic               cntClear,
    output logic               cntStep,
    // RAM port
    input  wire  lsuPkg::byteT ramRdata,
    output logic               ramEn,
    output logic               ramWe,
    output lsuPkg::addrT       ramAddr,
    output lsuPkg::byteT       ramWdata
);

    lsuPkg::ctrlStateT state;
    lsuPkg::ctrlStateT nextState;
    lsuPkg::dataT      laneReg;
    lsuPkg::dataT      merged;
    lsuPkg::dataT      sizeMask;
    logic [1:0]        prevIdx;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // state register and transitions
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= lsuPkg::ctrlIdle;
        end else if (flush) begin
            state <= lsuPkg::ctrlIdle;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = state;
        cntClear  = 1'b0;
        cntStep   = 1'b0;
        ramEn     = 1'b0;
        ramWe     = 1'b0;
        memDone   = 1'b0;
        case (state)
            lsuPkg::ctrlIdle: begin
                cntClear = 1'b1;  // every access starts from byte zero.
                if (memReq) begin
                    nextState = lsuPkg::ctrlAccess;
                end
            end
            lsuPkg::ctrlAccess: begin
                ramEn   = 1'b1;
                ramWe   = memStore;
                cntStep = !lastByte;  // the index stays on the last lane for finish.
                if (lastByte) begin
                    nextState = lsuPkg::ctrlFinish;
                end
            end
            lsuPkg::ctrlFinish: begin
                memDone   = 1'b1;
                nextState = lsuPkg::ctrlIdle;
            end
            default: nextState = lsuPkg::ctrlIdle;
        endcase
    end

    assign ramAddr  = memAddr + lsuPkg::addrT'(byteIdx);  // little-endian byte order.
    assign ramWdata = memData[byteIdx*8 +: 8];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // load data assembly
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign prevIdx = byteIdx - 2'd1;

    // read data lags the address by a cycle, so it lands in the previous lane.
    always_ff @(posedge clk) begin
        if (state == lsuPkg::ctrlAccess && !memStore && byteIdx != 2'd0) begin
            laneReg[prevIdx*8 +: 8] <= ramRdata;
        end
    end

    always_comb begin
        case (memSize)
            2'd0:    sizeMask = 32'h0000_00ff;
            2'd1:    sizeMask = 32'h0000_ffff;
            default: sizeMask = 32'hffff_ffff;
        endcase
        merged = laneReg;
        merged[byteIdx*8 +: 8] = ramRdata;
    end

    assign memRdata = merged & sizeMask;  // loads are zero-extended.

endmodule

`default_nettype wire

// File: source/lsuReqSlot.sv
`timescale 1ns/1ps
`default_nettype none

module lsuReqSlot (
    input  wire                clk,
    input  wire                arstN,
    input  wire                flush,
    // load/store buffer side
    input  wire                reqValid,
    input  wire                reqStore,
    input  wire  lsuPkg::addrT reqAddr,
    input  wire  lsuPkg::dataT reqData,
    input  wire  lsuPkg::sizeT reqSize,
    input  wire  lsuPkg::tagT  reqTag,
    output logic               ready,
    // memory controller side
    input  wire                memDone,
    input  wire  lsuPkg::dataT memRdata,
    output logic               memReq,
    output logic               memStore,
    output lsuPkg::addrT       memAddr,
    output lsuPkg::dataT       memData,
    output lsuPkg::sizeT       memSize,
    // response back to the buffer
    output logic               respDone,
    output lsuPkg::dataT       respData,
    output lsuPkg::tagT        respTag
);

    logic         occupied;
    logic         accept;
    logic         heldStore;
    lsuPkg::addrT heldAddr;
    lsuPkg::dataT heldData;
    lsuPkg::sizeT heldSize;
    lsuPkg::tagT  heldTag;

    assign accept = reqValid && !occupied;  // a strobe while full is dropped.

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            occupied <= 1'b0;
        end else if (flush || memDone) begin
            occupied <= 1'b0;
        end else if (accept) begin
            occupied <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            heldStore <= reqStore;
            heldAddr  <= reqAddr;
            heldData  <= reqData;
            heldSize  <= reqSize;
            heldTag   <= reqTag;
        end
    end

    assign ready    = !occupied;
    assign memReq   = occupied;
    assign memStore = heldStore;
    assign memAddr  = heldAddr;
    assign memData  = heldData;
    assign memSize  = heldSize;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // response, matched to the buffer entry by its tag
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign respDone = memDone;
    assign respData = (memDone && !heldStore) ? memRdata : '0;  // stores return nothing.
    assign respTag  = memDone ? heldTag : '0;

endmodule

`default_nettype wire

// File: source/lsuTop.sv
`timescale 1ns/1ps
`default_nettype none

module lsuTop (
    input  wire                clk,
    input  wire                arstN,
    input  wire                flush,
    input  wire                reqValid,
    input  wire                reqStore,
    input  wire  lsuPkg::addrT reqAddr,
    input  wire  lsuPkg::dataT reqData,
    input  wire  lsuPkg::sizeT reqSize,
    input  wire  lsuPkg::tagT  reqTag,
    output logic               ready,
    output logic               respDone,
    output lsuPkg::dataT       respData,
    output lsuPkg::tagT        respTag
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // internal wiring
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    logic         memReq;
    logic         memStore;
    lsuPkg::addrT memAddr;
    lsuPkg::dataT memData;
    lsuPkg::sizeT memSize;
    logic         memDone;
    lsuPkg::dataT memRdata;
    logic         cntClear;
    logic         cntStep;
    logic [1:0]   byteIdx;
    logic         lastByte;
    logic         ramEn;
    logic         ramWe;
    lsuPkg::addrT ramAddr;
    lsuPkg::byteT ramWdata;
    lsuPkg::byteT ramRdata;

    lsuReqSlot u_reqSlot (
        .clk, .arstN, .flush,
        .reqValid, .reqStore, .reqAddr, .reqData, .reqSize, .reqTag, .ready,
        .memDone, .memRdata, .memReq, .memStore, .memAddr, .memData, .memSize,
        .respDone, .respData, .respTag
    );

    memCtrlFsm u_memCtrlFsm (
        .clk, .arstN, .flush,
        .memReq, .memStore, .memAddr, .memData, .memSize, .memDone, .memRdata,
        .byteIdx, .lastByte, .cntClear, .cntStep,
        .ramRdata, .ramEn, .ramWe, .ramAddr, .ramWdata
    );

    byteCounter u_byteCounter (
        .clk, .arstN, .cntClear, .cntStep,
        .cntSize (memSize),
        .byteIdx, .lastByte
    );

    byteRam u_byteRam (
        .clk, .ramEn, .ramWe, .ramAddr, .ramWdata, .ramRdata
    );

endmodule

`default_nettype wire

// File: sim/lsuTopTb.sv
`timescale 1ns/1ps
`include "lsuMacros.svh"
`default_nettype none

module lsuTopTb;

    localparam int waitLimit = 50;

    logic         clk;
    logic         arstN;
    logic         flush;
    logic         reqValid;
    logic         reqStore;
    lsuPkg::addrT reqAddr;
    lsuPkg::dataT reqData;
    lsuPkg::sizeT reqSize;
    lsuPkg::tagT  reqTag;
    logic         ready;
    logic         respDone;
    lsuPkg::dataT respData;
    lsuPkg::tagT  respTag;

    logic [7:0]   refMem [`LSU_RAM_DEPTH];  // byte image of every store.
    logic         busy;
    int           seed = 32'h15da_a2ca;
    int           errCount = 0;
    int           propErrs = 0;
    int           testCount = 0;
    int           testErrStart;
    string        testName;

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    lsuTop u_lsuTop (
        .clk, .arstN, .flush,
        .reqValid, .reqStore, .reqAddr, .reqData, .reqSize, .reqTag,
        .ready, .respDone, .respData, .respTag
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // protocol properties
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            busy <= 1'b0;
        end else if (flush || respDone) begin
            busy <= 1'b0;
        end else if (reqValid && ready) begin
            busy <= 1'b1;  // set on the accepting edge.
        end
    end

    respStrobe: assert property (@(posedge clk) disable iff (!arstN) respDone |=> !respDone)
        else begin
            $display("respDone stayed high for two cycles in a row");
            propErrs++;
        end

    slotBusy: assert property (@(posedge clk) disable iff (!arstN) busy |-> !ready)
        else begin
            $display("ready went high while a request was still in flight");
            propErrs++;
        end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic lsuPkg::dataT randWord();
        return lsuPkg::dataT'($random(seed));
    endfunction

    function automatic lsuPkg::addrT randAddr(input lsuPkg::sizeT size);
        lsuPkg::dataT r;
        lsuPkg::addrT addr;
        r = randWord();
        addr = r[`LSU_ADDR_W-1:0];
        if (size == 2'd1) begin
            addr[0] = 1'b0;
        end else if (size == 2'd2) begin
            addr[1:0] = 2'b00;
        end
        return addr;
    endfunction

    // upper bytes stay zero and the rest come little-endian from the image.
    function automatic lsuPkg::dataT expectedLoad(input lsuPkg::addrT addr,
                                                  input lsuPkg::sizeT size);
        lsuPkg::dataT value;
        value = '0;
        for (int k = 0; k < (1 << size); k++) begin
            value[k*8 +: 8] = refMem[addr + lsuPkg::addrT'(k)];
        end
        return value;
    endfunction

    task automatic endRun();
        $display("tests run %0d, errors %0d", testCount, errCount + propErrs);
        if (errCount + propErrs == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    endtask

    task automatic beginTest(input string name);
        testName = name;
        testErrStart = errCount + propErrs;
    endtask

    task automatic endTest();
        testCount++;
        if (errCount + propErrs == testErrStart) begin
            $display("test %s ok", testName);
        end else begin
            $display("test %s failed with %0d errors", testName,
                     errCount + propErrs - testErrStart);
        end
    endtask

    task automatic checkValue(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
        assert (actual === expected)
            else begin
                $display("mismatch %s %s expected %h actual %h", testName, what,
                         expected, actual);
                errCount++;
            end
    endtask

    task automatic nextCycle();
        @(posedge clk);
        #1;
    endtask

    task automatic waitReady();
        int cnt;
        cnt = 0;
        while (!ready && cnt < waitLimit) begin
            nextCycle();
            cnt++;
        end
        if (!ready) begin
            $display("timeout in %s, ready never came back", testName);
            errCount++;
            endRun();
        end
    endtask

    // the request is taken on the edge inside this one-cycle strobe.
    task automatic driveReq(input logic store, input lsuPkg::addrT addr,
                            input lsuPkg::dataT data, input lsuPkg::sizeT size,
                            input lsuPkg::tagT tag);
        waitReady();
        reqValid = 1'b1;
        reqStore = store;
        reqAddr  = addr;
        reqData  = data;
        reqSize  = size;
        reqTag   = tag;
        nextCycle();
        reqValid = 1'b0;
        reqStore = !store;  // only the held copy may be used from here on.
        reqAddr  = ~addr;
        reqData  = ~data;
        reqSize  = ~size;
        reqTag   = ~tag;
    endtask

    task automatic issueReq(input logic store, input lsuPkg::addrT addr,
                            input lsuPkg::dataT data, input lsuPkg::sizeT size,
                            output int cycles);
        lsuPkg::dataT r;
        lsuPkg::dataT expected;
        r = randWord();
        expected = store ? '0 : expectedLoad(addr, size);
        driveReq(store, addr, data, size, r[`LSU_TAG_W-1:0]);
        cycles = 0;
        while (!respDone && cycles < waitLimit) begin
            nextCycle();
            cycles++;
        end
        if (!respDone) begin
            $display("timeout in %s, no response after %0d cycles", testName, cycles);
            errCount++;
            endRun();
        end else begin
            checkValue("respData", expected, respData);
            checkValue("respTag", 32'(r[`LSU_TAG_W-1:0]), 32'(respTag));
            if (store) begin
                for (int k = 0; k < (1 << size); k++) begin
                    refMem[addr + lsuPkg::addrT'(k)] = data[k*8 +: 8];
                end
            end
            nextCycle();
            checkValue("ready after response", 32'd1, 32'(ready));
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // test sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        int           cycles;
        lsuPkg::addrT base;
        lsuPkg::addrT wordBase;
        lsuPkg::dataT word;
        lsuPkg::sizeT size;
        arstN    = 1'b0;
        flush    = 1'b0;
        reqValid = 1'b0;
        reqStore = 1'b0;
        reqAddr  = '0;
        reqData  = '0;
        reqSize  = '0;
        reqTag   = '0;
        repeat (10) @(posedge clk);
        #1 arstN = 1'b1;

        beginTest("reset");
        checkValue("ready", 32'd1, 32'(ready));
        checkValue("respDone", 32'd0, 32'(respDone));
        endTest();

        beginTest("wordLoop");
        repeat (20) begin
            base = randAddr(2'd2);
            issueReq(1'b1, base, randWord(), 2'd2, cycles);
            issueReq(1'b0, base, '0, 2'd2, cycles);
        end
        endTest();

        beginTest("subword");
        wordBase = randAddr(2'd2);
        issueReq(1'b1, wordBase, randWord(), 2'd2, cycles);
        issueReq(1'b1, wordBase + 17'd1, randWord(), 2'd0, cycles);
        issueReq(1'b1, wordBase + 17'd2, randWord(), 2'd1, cycles);
        for (int k = 0; k < 4; k++) begin
            issueReq(1'b0, wordBase + lsuPkg::addrT'(k), '0, 2'd0, cycles);
        end
        issueReq(1'b0, wordBase, '0, 2'd1, cycles);
        issueReq(1'b0, wordBase + 17'd2, '0, 2'd1, cycles);
        issueReq(1'b0, wordBase, '0, 2'd2, cycles);
        endTest();

        beginTest("tags");
        repeat (12) begin
            word = randWord();
            size = lsuPkg::sizeT'(word % 3);
            base = randAddr(size);
            issueReq(1'b1, base, randWord(), size, cycles);
            issueReq(1'b0, base, '0, size, cycles);
        end
        endTest();

        beginTest("latency");
        issueReq(1'b0, wordBase, '0, 2'd0, cycles);
        checkValue("byte cycles", 32'd2, 32'(cycles));
        issueReq(1'b0, wordBase, '0, 2'd1, cycles);
        checkValue("halfword cycles", 32'd3, 32'(cycles));
        issueReq(1'b0, wordBase, '0, 2'd2, cycles);
        checkValue("word cycles", 32'd5, 32'(cycles));
        endTest();

        beginTest("flush");
        word = randWord();
        driveReq(1'b0, wordBase, '0, 2'd2, word[`LSU_TAG_W-1:0]);
        nextCycle();  // controller is in access now.
        flush = 1'b1;
        nextCycle();
        flush = 1'b0;
        checkValue("ready after flush", 32'd1, 32'(ready));
        repeat (8) begin
            nextCycle();
            checkValue("respDone after flush", 32'd0, 32'(respDone));
        end
        issueReq(1'b0, wordBase, '0, 2'd2, cycles);
        endTest();

        endRun();
    end

endmodule

`default_nettype wire

// File: list.f
+incdir+source
source/lsuPkg.sv
source/byteCounter.sv
source/byteRam.sv
source/memCtrlFsm.sv
source/lsuReqSlot.sv
source/lsuTop.sv
sim/lsuTopTb.sv

// File: Makefile
# Verilator build and run of the data-memory path testbench.

VERILATOR ?= verilator
TOP       ?= lsuTopTb
FILELIST  ?= list.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= *** PASSED ***

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, and check for the pass message"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	@out=$$(./$(OBJDIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -qF '$(PASS_TEXT)'

clean:
	rm -rf $(OBJDIR)
